// File: src/pcap_replay_pkg.sv
// Packet capture and replay engine: shared widths, port numbers, memory layout and FSM states
package pcap_replay_pkg;

  localparam int TDATA_W              = 64;
  localparam int TKEEP_W              = 8;
  localparam int TUSER_W              = 64;
  localparam int MEM_ADDR_W           = 6;
  localparam int FIFO_DEPTH_W         = 3;
  localparam int FIFO_DEPTH           = 1 << FIFO_DEPTH_W;
  // free slots below this count as nearly full, covers the in-flight read
  localparam int FIFO_NEARLY_FULL_GAP = 2;
  localparam int COUNT_W              = 16;

  // port fields inside the user word
  localparam int SRC_PORT_LSB = 16;
  localparam int DST_PORT_LSB = 24;

  typedef logic [TDATA_W-1:0]      tdata_t;
  typedef logic [TKEEP_W-1:0]      tkeep_t;
  typedef logic [TUSER_W-1:0]      tuser_t;
  typedef logic [MEM_ADDR_W-1:0]   mem_addr_t;
  typedef logic [COUNT_W-1:0]      count_t;
  typedef logic [7:0]              port_t;
  typedef logic [FIFO_DEPTH_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_DEPTH_W:0]   fifo_cnt_t;

  localparam port_t CAPTURE_SRC_PORT = 8'h02;
  localparam port_t TX_DST_PORT      = 8'h01;

  // memory word from the top: done, valid, tlast, tuser, tkeep, tdata
  localparam int MEM_TKEEP_LSB = TDATA_W;
  localparam int MEM_TUSER_LSB = MEM_TKEEP_LSB + TKEEP_W;
  localparam int MEM_TLAST_POS = MEM_TUSER_LSB + TUSER_W;
  localparam int MEM_VALID_POS = MEM_TLAST_POS + 1;
  localparam int MEM_DONE_POS  = MEM_VALID_POS + 1;
  localparam int MEM_WORD_W    = MEM_DONE_POS + 1;

  typedef logic [MEM_WORD_W-1:0] mem_word_t;

  // highest occupancy at which the FIFO still accepts new reads
  localparam fifo_cnt_t FIFO_READY_MAX = fifo_cnt_t'(FIFO_DEPTH - FIFO_NEARLY_FULL_GAP);

  typedef enum logic {WR_IDLE, WR_CAPTURE} wr_state_e;
  typedef enum logic {RD_IDLE, RD_READ} rd_state_e;
  typedef enum logic {TX_IDLE, TX_SEND} tx_state_e;

endpackage

// File: src/pcap_beat_if.sv
// Stream beat link between the replay reader, the replay FIFO and the transmit stage
`timescale 1ns/1ns

interface pcap_beat_if;

  pcap_replay_pkg::tdata_t tdata;
  pcap_replay_pkg::tkeep_t tkeep;
  pcap_replay_pkg::tuser_t tuser;
  logic                    tlast;
  logic                    valid;
  logic                    ready;

  modport src (
    output tdata, tkeep, tuser, tlast, valid,
    input  ready
  );

  modport dst (
    input  tdata, tkeep, tuser, tlast, valid,
    output ready
  );

endinterface

// File: src/pcap_capture_writer.sv
// Capture writer: stores beats from the capture port into packet memory and marks the end
`timescale 1ns/1ns

module pcap_capture_writer (
  input  logic                       axis_aclk,
  input  logic                       axis_aresetn,
  input  logic                       sw_rst,
  input  pcap_replay_pkg::tdata_t    s_tdata,
  input  pcap_replay_pkg::tkeep_t    s_tkeep,
  input  pcap_replay_pkg::tuser_t    s_tuser,
  input  logic                       s_tlast,
  input  logic                       s_tvalid,
  input  logic                       wr_done,
  output pcap_replay_pkg::mem_addr_t wr_addr,
  output pcap_replay_pkg::mem_word_t wr_word,
  output logic                       wr_en
);

  pcap_replay_pkg::wr_state_e state, state_next;
  pcap_replay_pkg::mem_addr_t addr, addr_next;
  pcap_replay_pkg::mem_word_t word_next;
  logic                       we_next;
  logic                       src_match;

  // capture opens on the first beat from the watched port
  assign src_match = s_tvalid &&
      (s_tuser[pcap_replay_pkg::SRC_PORT_LSB +: 8] == pcap_replay_pkg::CAPTURE_SRC_PORT);

  always_comb begin
    state_next = state;
    addr_next  = addr;
    we_next    = 1'b0;
    word_next  = '0;
    case (state)
      pcap_replay_pkg::WR_IDLE: begin
        if (src_match) begin
          we_next    = 1'b1;
          word_next  = {1'b0, 1'b1, s_tlast, s_tuser, s_tkeep, s_tdata};
          addr_next  = addr + pcap_replay_pkg::mem_addr_t'(1);
          state_next = pcap_replay_pkg::WR_CAPTURE;
        end
      end
      pcap_replay_pkg::WR_CAPTURE: begin
        // done marker wins over a beat in the same cycle
        if (wr_done) begin
          we_next                               = 1'b1;
          word_next[pcap_replay_pkg::MEM_DONE_POS] = 1'b1;
          addr_next                             = pcap_replay_pkg::mem_addr_t'(1);
          state_next                            = pcap_replay_pkg::WR_IDLE;
        end else if (s_tvalid) begin
          we_next   = 1'b1;
          word_next = {1'b0, 1'b1, s_tlast, s_tuser, s_tkeep, s_tdata};
          addr_next = addr + pcap_replay_pkg::mem_addr_t'(1);
        end
      end
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || sw_rst) begin
      state <= pcap_replay_pkg::WR_IDLE;
      addr  <= pcap_replay_pkg::mem_addr_t'(1);
      wr_en <= 1'b0;
    end else begin
      state <= state_next;
      addr  <= addr_next;
      wr_en <= we_next;
    end
  end

  // write port register stage
  always_ff @(posedge axis_aclk) begin
    wr_addr <= addr;
    wr_word <= word_next;
  end

endmodule

// File: src/pcap_packet_ram.sv
// Packet memory: single-port synchronous RAM, one captured beat per word
`timescale 1ns/1ns

module pcap_packet_ram (
  input  logic                       axis_aclk,
  input  pcap_replay_pkg::mem_addr_t wr_addr,
  input  pcap_replay_pkg::mem_word_t wr_word,
  input  logic                       wr_en,
  input  pcap_replay_pkg::mem_addr_t rd_addr,
  input  logic                       rd_en,
  output pcap_replay_pkg::mem_word_t rd_word
);

  pcap_replay_pkg::mem_word_t mem [0:(1 << pcap_replay_pkg::MEM_ADDR_W)-1];
  pcap_replay_pkg::mem_addr_t port_addr;

  // one address port, the writer takes it over the reader
  assign port_addr = wr_en ? wr_addr : rd_addr;

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[port_addr] <= wr_word;
    end else if (rd_en) begin
      rd_word <= mem[port_addr];
    end
  end

endmodule

// File: src/pcap_replay_reader.sv
// Replay reader: reads packet memory in passes up to the done marker and feeds the FIFO
`timescale 1ns/1ns

module pcap_replay_reader (
  input  logic                       axis_aclk,
  input  logic                       axis_aresetn,
  input  logic                       sw_rst,
  input  logic                       start,
  input  pcap_replay_pkg::count_t    replay_count,
  input  pcap_replay_pkg::mem_word_t rd_word,
  output pcap_replay_pkg::mem_addr_t rd_addr,
  output logic                       rd_en,
  pcap_beat_if.src                   beat
);

  pcap_replay_pkg::rd_state_e state;
  pcap_replay_pkg::count_t    pass_cnt;
  logic                       start_q;
  logic                       start_edge;
  logic                       ret_q;
  logic                       drop_q;
  logic                       live;
  logic                       done_hit;
  logic                       last_pass;

  // start edge, registered so it is seen one cycle late
  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn) begin
      start_q    <= 1'b0;
      start_edge <= 1'b0;
    end else begin
      start_q    <= start;
      start_edge <= start & ~start_q;
    end
  end

  // ret_q marks a word on rd_word this cycle, drop_q the read issued alongside a marker
  assign live      = ret_q && !drop_q;
  assign done_hit  = live && rd_word[pcap_replay_pkg::MEM_DONE_POS];
  assign last_pass = (pass_cnt + pcap_replay_pkg::count_t'(1)) >= replay_count;

  // no new read once the FIFO is nearly full
  assign rd_en = (state == pcap_replay_pkg::RD_READ) && beat.ready;

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || sw_rst) begin
      state    <= pcap_replay_pkg::RD_IDLE;
      rd_addr  <= pcap_replay_pkg::mem_addr_t'(1);
      pass_cnt <= '0;
      ret_q    <= 1'b0;
      drop_q   <= 1'b0;
    end else begin
      ret_q  <= rd_en;
      drop_q <= done_hit;
      case (state)
        pcap_replay_pkg::RD_IDLE: begin
          if (start_edge && (replay_count != '0)) begin
            state    <= pcap_replay_pkg::RD_READ;
            rd_addr  <= pcap_replay_pkg::mem_addr_t'(1);
            pass_cnt <= '0;
          end
        end
        pcap_replay_pkg::RD_READ: begin
          if (done_hit) begin
            // pass complete, rewind
            rd_addr <= pcap_replay_pkg::mem_addr_t'(1);
            if (last_pass) begin
              state    <= pcap_replay_pkg::RD_IDLE;
              pass_cnt <= '0;
            end else begin
              pass_cnt <= pass_cnt + pcap_replay_pkg::count_t'(1);
            end
          end else if (rd_en) begin
            rd_addr <= rd_addr + pcap_replay_pkg::mem_addr_t'(1);
          end
        end
      endcase
    end
  end

  // returned beats go straight into the FIFO
  assign beat.valid = live && rd_word[pcap_replay_pkg::MEM_VALID_POS];
  assign beat.tdata = rd_word[0 +: pcap_replay_pkg::TDATA_W];
  assign beat.tkeep = rd_word[pcap_replay_pkg::MEM_TKEEP_LSB +: pcap_replay_pkg::TKEEP_W];
  assign beat.tuser = rd_word[pcap_replay_pkg::MEM_TUSER_LSB +: pcap_replay_pkg::TUSER_W];
  assign beat.tlast = rd_word[pcap_replay_pkg::MEM_TLAST_POS];

endmodule

// File: src/replay_fifo.sv
// Replay FIFO: small fall-through buffer with a nearly-full level toward the reader
`timescale 1ns/1ns

module replay_fifo (
  input  logic     axis_aclk,
  input  logic     axis_aresetn,
  pcap_beat_if.dst wr_side,
  pcap_beat_if.src rd_side
);

  pcap_replay_pkg::tdata_t    tdata_mem [pcap_replay_pkg::FIFO_DEPTH];
  pcap_replay_pkg::tkeep_t    tkeep_mem [pcap_replay_pkg::FIFO_DEPTH];
  pcap_replay_pkg::tuser_t    tuser_mem [pcap_replay_pkg::FIFO_DEPTH];
  logic                       tlast_mem [pcap_replay_pkg::FIFO_DEPTH];
  pcap_replay_pkg::fifo_ptr_t wr_ptr;
  pcap_replay_pkg::fifo_ptr_t rd_ptr;
  pcap_replay_pkg::fifo_cnt_t count;
  logic                       push;
  logic                       pop;

  assign push = wr_side.valid;
  assign pop  = rd_side.valid && rd_side.ready;

  always_ff @(posedge axis_aclk) begin
    if (push) begin
      tdata_mem[wr_ptr] <= wr_side.tdata;
      tkeep_mem[wr_ptr] <= wr_side.tkeep;
      tuser_mem[wr_ptr] <= wr_side.tuser;
      tlast_mem[wr_ptr] <= wr_side.tlast;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + pcap_replay_pkg::fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + pcap_replay_pkg::fifo_ptr_t'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + pcap_replay_pkg::fifo_cnt_t'(1);
        2'b01:   count <= count - pcap_replay_pkg::fifo_cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

  // ready is advance warning, not a per-beat acknowledge
  assign wr_side.ready = (count <= pcap_replay_pkg::FIFO_READY_MAX);

  // head beat shows while not empty
  assign rd_side.valid = (count != '0);
  assign rd_side.tdata = tdata_mem[rd_ptr];
  assign rd_side.tkeep = tkeep_mem[rd_ptr];
  assign rd_side.tuser = tuser_mem[rd_ptr];
  assign rd_side.tlast = tlast_mem[rd_ptr];

endmodule

// File: src/pcap_tx_stage.sv
// Transmit stage: frames replayed packets onto the output stream and rewrites the port fields
`timescale 1ns/1ns

module pcap_tx_stage (
  input  logic                    axis_aclk,
  input  logic                    axis_aresetn,
  input  logic                    m_axis_tready,
  pcap_beat_if.dst                beat,
  output pcap_replay_pkg::tdata_t m_axis_tdata,
  output pcap_replay_pkg::tkeep_t m_axis_tkeep,
  output pcap_replay_pkg::tuser_t m_axis_tuser,
  output logic                    m_axis_tlast,
  output logic                    m_axis_tvalid
);

  pcap_replay_pkg::tx_state_e state, state_next;
  pcap_replay_pkg::tuser_t    tuser_rw;
  logic                       move;

  // upper half kept, ports replaced, low 16 bits cleared
  always_comb begin
    tuser_rw = beat.tuser;
    tuser_rw[pcap_replay_pkg::SRC_PORT_LSB-1:0]  = '0;
    tuser_rw[pcap_replay_pkg::SRC_PORT_LSB +: 8] = pcap_replay_pkg::CAPTURE_SRC_PORT;
    tuser_rw[pcap_replay_pkg::DST_PORT_LSB +: 8] = pcap_replay_pkg::TX_DST_PORT;
  end

  assign move       = (state == pcap_replay_pkg::TX_SEND) && beat.valid && m_axis_tready;
  assign beat.ready = move;

  always_comb begin
    state_next    = state;
    m_axis_tdata  = '0;
    m_axis_tkeep  = '0;
    m_axis_tuser  = '0;
    m_axis_tlast  = 1'b0;
    m_axis_tvalid = 1'b0;
    case (state)
      pcap_replay_pkg::TX_IDLE: begin
        if (m_axis_tready && beat.valid) begin
          state_next = pcap_replay_pkg::TX_SEND;
        end
      end
      pcap_replay_pkg::TX_SEND: begin
        m_axis_tdata  = beat.tdata;
        m_axis_tkeep  = beat.tkeep;
        m_axis_tuser  = tuser_rw;
        m_axis_tlast  = beat.tlast;
        m_axis_tvalid = beat.valid;
        // back to idle once the packet end leaves
        if (move && beat.tlast) begin
          state_next = pcap_replay_pkg::TX_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn) begin
      state <= pcap_replay_pkg::TX_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

// File: src/pcap_replay_top.sv
// Packet capture and replay engine top: writer, packet memory, reader, FIFO and transmit stage
`timescale 1ns/1ns

module pcap_replay_top (
  input  logic                    axis_aclk,
  input  logic                    axis_aresetn,
  input  logic                    sw_rst,
  input  logic                    wr_done,
  input  logic                    start,
  input  pcap_replay_pkg::count_t replay_count,
  input  pcap_replay_pkg::tdata_t s_axis_tdata,
  input  pcap_replay_pkg::tkeep_t s_axis_tkeep,
  input  pcap_replay_pkg::tuser_t s_axis_tuser,
  input  logic                    s_axis_tlast,
  input  logic                    s_axis_tvalid,
  output pcap_replay_pkg::tdata_t m_axis_tdata,
  output pcap_replay_pkg::tkeep_t m_axis_tkeep,
  output pcap_replay_pkg::tuser_t m_axis_tuser,
  output logic                    m_axis_tlast,
  output logic                    m_axis_tvalid,
  input  logic                    m_axis_tready
);

  pcap_replay_pkg::mem_addr_t wr_addr;
  pcap_replay_pkg::mem_word_t wr_word;
  logic                       wr_en;
  pcap_replay_pkg::mem_addr_t rd_addr;
  pcap_replay_pkg::mem_word_t rd_word;
  logic                       rd_en;

  pcap_beat_if beat_to_fifo ();
  pcap_beat_if beat_to_tx ();

  pcap_capture_writer u_writer (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .sw_rst       (sw_rst),
    .s_tdata      (s_axis_tdata),
    .s_tkeep      (s_axis_tkeep),
    .s_tuser      (s_axis_tuser),
    .s_tlast      (s_axis_tlast),
    .s_tvalid     (s_axis_tvalid),
    .wr_done      (wr_done),
    .wr_addr      (wr_addr),
    .wr_word      (wr_word),
    .wr_en        (wr_en)
  );

  pcap_packet_ram u_ram (
    .axis_aclk (axis_aclk),
    .wr_addr   (wr_addr),
    .wr_word   (wr_word),
    .wr_en     (wr_en),
    .rd_addr   (rd_addr),
    .rd_en     (rd_en),
    .rd_word   (rd_word)
  );

  pcap_replay_reader u_reader (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .sw_rst       (sw_rst),
    .start        (start),
    .replay_count (replay_count),
    .rd_word      (rd_word),
    .rd_addr      (rd_addr),
    .rd_en        (rd_en),
    .beat         (beat_to_fifo)
  );

  replay_fifo u_fifo (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .wr_side      (beat_to_fifo),
    .rd_side      (beat_to_tx)
  );

  pcap_tx_stage u_tx (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .m_axis_tready (m_axis_tready),
    .beat          (beat_to_tx),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid)
  );

endmodule

// File: bench/tb_pcap_replay_tasks.svh
// Compare tasks and input beat driver for the packet capture and replay testbench

task automatic check_data(input string name, input pcap_replay_pkg::tdata_t expected,
                          input pcap_replay_pkg::tdata_t actual);
  if (expected !== actual) begin
    $display("[FAIL] %s tdata: expected %h, actual %h", name, expected, actual);
    err_count++;
  end
endtask

task automatic check_keep(input string name, input pcap_replay_pkg::tkeep_t expected,
                          input pcap_replay_pkg::tkeep_t actual);
  if (expected !== actual) begin
    $display("[FAIL] %s tkeep: expected %h, actual %h", name, expected, actual);
    err_count++;
  end
endtask

task automatic check_user(input string name, input pcap_replay_pkg::tuser_t expected,
                          input pcap_replay_pkg::tuser_t actual);
  if (expected !== actual) begin
    $display("[FAIL] %s tuser: expected %h, actual %h", name, expected, actual);
    err_count++;
  end
endtask

task automatic check_last(input string name, input logic expected, input logic actual);
  if (expected !== actual) begin
    $display("[FAIL] %s tlast: expected %b, actual %b", name, expected, actual);
    err_count++;
  end
endtask

// one input beat, driven just after the clock edge
task automatic send_beat(input pcap_replay_pkg::tdata_t d, input pcap_replay_pkg::tkeep_t k,
                         input pcap_replay_pkg::tuser_t u, input logic l);
  @(posedge axis_aclk);
  #1;
  s_axis_tdata  = d;
  s_axis_tkeep  = k;
  s_axis_tuser  = u;
  s_axis_tlast  = l;
  s_axis_tvalid = 1'b1;
endtask

// File: bench/tb_pcap_replay.sv
// Testbench for the packet capture and replay engine with table-driven capture, replay and compare
`timescale 1ns/1ns

module tb_pcap_replay;

  localparam int NUM_TESTS    = 6;
  localparam int WAIT_LIMIT   = 2000;
  localparam int QUIET_CYCLES = 40;

  logic                    axis_aclk;
  logic                    axis_aresetn;
  logic                    sw_rst;
  logic                    wr_done;
  logic                    start;
  pcap_replay_pkg::count_t replay_count;
  pcap_replay_pkg::tdata_t s_axis_tdata;
  pcap_replay_pkg::tkeep_t s_axis_tkeep;
  pcap_replay_pkg::tuser_t s_axis_tuser;
  logic                    s_axis_tlast;
  logic                    s_axis_tvalid;
  pcap_replay_pkg::tdata_t m_axis_tdata;
  pcap_replay_pkg::tkeep_t m_axis_tkeep;
  pcap_replay_pkg::tuser_t m_axis_tuser;
  logic                    m_axis_tlast;
  logic                    m_axis_tvalid;
  logic                    m_axis_tready;

  // stimulus table columns are name, packet lengths, replay count, back-pressure, sw reset,
  // non-matching lead-in beats and expected output beats
  string t_name   [NUM_TESTS] = '{"pre_capture_filter", "single_replay", "triple_replay",
                                  "triple_backpressure", "zero_count", "sw_reset_recapture"};
  int    t_len0   [NUM_TESTS] = '{3, 4, 3, 3, 2, 4};
  int    t_len1   [NUM_TESTS] = '{2, 1, 5, 5, 2, 3};
  int    t_len2   [NUM_TESTS] = '{0, 3, 2, 2, 0, 0};
  int    t_count  [NUM_TESTS] = '{1, 1, 3, 3, 0, 2};
  bit    t_bp     [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  bit    t_swrst  [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
  int    t_lead   [NUM_TESTS] = '{3, 0, 0, 0, 0, 0};
  int    t_expect [NUM_TESTS] = '{5, 8, 30, 30, 0, 14};

  // captured beats and the expected output model
  pcap_replay_pkg::tdata_t cap_data [$];
  pcap_replay_pkg::tkeep_t cap_keep [$];
  pcap_replay_pkg::tuser_t cap_user [$];
  logic                    cap_last [$];
  pcap_replay_pkg::tdata_t exp_data [$];
  pcap_replay_pkg::tkeep_t exp_keep [$];
  pcap_replay_pkg::tuser_t exp_user [$];
  logic                    exp_last [$];

  int          err_count;
  int          errs_before;
  int          pass_tests;
  int          fail_tests;
  int          got_beats;

  pcap_replay_top DUT (.*);

  `include "tb_pcap_replay_tasks.svh"

  initial begin
    axis_aclk = 1'b0;
    forever #5 axis_aclk = ~axis_aclk;
  end

  // output user word keeps the upper half, sets ports 01 and 02 and clears the low 16 bits
  function automatic pcap_replay_pkg::tuser_t expect_user(input pcap_replay_pkg::tuser_t u);
    return {u[63:32], 8'h01, 8'h02, 16'h0000};
  endfunction

  task automatic capture_packets(input int t);
    pcap_replay_pkg::tuser_t u;
    pcap_replay_pkg::tkeep_t k;
    int                      lens [3];
    lens = '{t_len0[t], t_len1[t], t_len2[t]};
    cap_data.delete();
    cap_keep.delete();
    cap_user.delete();
    cap_last.delete();
    // lead-in beats from another source port that must not be stored
    for (int i = 0; i < t_lead[t]; i++) begin
      u = {$urandom, $urandom};
      u[23:16] = 8'h7e;
      send_beat({$urandom, $urandom}, 8'hff, u, 1'b0);
    end
    for (int p = 0; p < 3; p++) begin
      for (int b = 0; b < lens[p]; b++) begin
        u = {$urandom, $urandom};
        if (cap_data.size() == 0) begin
          u[23:16] = 8'h02;
        end
        k = (b == lens[p] - 1) ? pcap_replay_pkg::tkeep_t'(8'hff >> ($urandom % 8)) : 8'hff;
        cap_data.push_back({$urandom, $urandom});
        cap_keep.push_back(k);
        cap_user.push_back(u);
        cap_last.push_back(b == lens[p] - 1);
        send_beat(cap_data[$], k, u, cap_last[$]);
      end
    end
    @(posedge axis_aclk);
    #1;
    s_axis_tvalid = 1'b0;
    wr_done       = 1'b1;
    @(posedge axis_aclk);
    #1;
    wr_done = 1'b0;
  endtask

  task automatic build_model(input int count);
    exp_data.delete();
    exp_keep.delete();
    exp_user.delete();
    exp_last.delete();
    for (int r = 0; r < count; r++) begin
      for (int i = 0; i < cap_data.size(); i++) begin
        exp_data.push_back(cap_data[i]);
        exp_keep.push_back(cap_keep[i]);
        exp_user.push_back(expect_user(cap_user[i]));
        exp_last.push_back(cap_last[i]);
      end
    end
  endtask

  task automatic pulse_start();
    @(posedge axis_aclk);
    #1;
    start = 1'b1;
    @(posedge axis_aclk);
    #1;
    start = 1'b0;
  endtask

  // output held off while the reset pulse is applied
  task automatic pulse_sw_rst();
    @(posedge axis_aclk);
    #1;
    sw_rst        = 1'b1;
    m_axis_tready = 1'b0;
    @(posedge axis_aclk);
    #1;
    sw_rst = 1'b0;
  endtask

  // beats sampled at the falling edge before they move on the rising edge
  task automatic collect_beats(input string name, input int n, input bit bp);
    int    cycles;
    int    got;
    string tag;
    cycles = 0;
    got    = 0;
    while (got < n && cycles < WAIT_LIMIT) begin
      @(posedge axis_aclk);
      #1;
      m_axis_tready = bp ? (($urandom % 3) != 0) : 1'b1;
      @(negedge axis_aclk);
      cycles++;
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_data.size() == 0) begin
          $display("ERROR: %s output beat arrived with no beat left in the model", name);
          err_count++;
        end else begin
          tag = $sformatf("%s beat %0d", name, got_beats);
          check_data(tag, exp_data.pop_front(), m_axis_tdata);
          check_keep(tag, exp_keep.pop_front(), m_axis_tkeep);
          check_user(tag, exp_user.pop_front(), m_axis_tuser);
          check_last(tag, exp_last.pop_front(), m_axis_tlast);
        end
        got++;
        got_beats++;
      end
    end
    if (got < n) begin
      $display("ERROR: %s timed out after %0d cycles with %0d of %0d beats", name, cycles,
               got, n);
      err_count++;
    end
  endtask

  task automatic expect_quiet(input string name);
    for (int c = 0; c < QUIET_CYCLES; c++) begin
      @(posedge axis_aclk);
      #1;
      m_axis_tready = 1'b1;
      @(negedge axis_aclk);
      if (m_axis_tvalid) begin
        $display("ERROR: %s output valid when no beat was expected", name);
        err_count++;
      end
    end
  endtask

  task automatic drain_output(input string name);
    int cycles;
    int quiet;
    int drained;
    cycles  = 0;
    quiet   = 0;
    drained = 0;
    while (quiet < 8 && cycles < WAIT_LIMIT) begin
      @(posedge axis_aclk);
      #1;
      m_axis_tready = 1'b1;
      @(negedge axis_aclk);
      cycles++;
      if (m_axis_tvalid) begin
        drained++;
      end
      quiet = m_axis_tvalid ? 0 : quiet + 1;
    end
    if (quiet < 8) begin
      $display("ERROR: %s output did not go idle after the software reset", name);
      err_count++;
    end
    // only beats already buffered in the FIFO may still leave
    if (drained >= exp_data.size()) begin
      $display("ERROR: %s replay kept running after the software reset, %0d beats drained",
               name, drained);
      err_count++;
    end
  endtask

  task automatic report_test(input string name);
    if (err_count == errs_before) begin
      $display("test %s: ok, %0d beats", name, got_beats);
      pass_tests++;
    end else begin
      $display("test %s: %0d errors", name, err_count - errs_before);
      fail_tests++;
    end
  endtask

  initial begin
    void'($urandom(32'h9144eb03));
    err_count     = 0;
    pass_tests    = 0;
    fail_tests    = 0;
    got_beats     = 0;
    axis_aresetn  = 1'b0;
    sw_rst        = 1'b0;
    wr_done       = 1'b0;
    start         = 1'b0;
    replay_count  = '0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tuser  = '0;
    s_axis_tlast  = 1'b0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    repeat (2) @(posedge axis_aclk);
    #1;
    axis_aresetn = 1'b1;

    // output stays idle with nothing captured yet
    errs_before = err_count;
    expect_quiet("reset_idle");
    report_test("reset_idle");

    for (int t = 0; t < NUM_TESTS; t++) begin
      errs_before  = err_count;
      got_beats    = 0;
      replay_count = pcap_replay_pkg::count_t'(t_count[t]);
      capture_packets(t);
      build_model(t_count[t]);
      pulse_start();
      if (t_swrst[t]) begin
        // stop mid-replay and capture fresh packets
        collect_beats(t_name[t], 3, t_bp[t]);
        pulse_sw_rst();
        drain_output(t_name[t]);
        capture_packets(t);
        build_model(t_count[t]);
        pulse_start();
        got_beats = 0;
      end
      collect_beats(t_name[t], t_expect[t], t_bp[t]);
      expect_quiet(t_name[t]);
      if (exp_data.size() != 0) begin
        $display("ERROR: %s ended with %0d model beats never sent", t_name[t], exp_data.size());
        err_count++;
      end
      report_test(t_name[t]);
    end

    $display("tests: %0d passed, %0d failed", pass_tests, fail_tests);
    if (err_count == 0 && fail_tests == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+bench
src/pcap_replay_pkg.sv
src/pcap_beat_if.sv
src/pcap_capture_writer.sv
src/pcap_packet_ram.sv
src/pcap_replay_reader.sv
src/replay_fifo.sv
src/pcap_tx_stage.sv
src/pcap_replay_top.sv
bench/tb_pcap_replay.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module tb_pcap_replay \
  -f verilog.f -o sim_tb &&
  ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && echo "result: pass" && exit 0 || {
  echo "result: fail"
  exit 1
}
